// File: mips_ldst.f
mips_ldst_pkg.sv
cycle_sequencer.sv
instr_decoder.sv
load_store.sv
register_file.sv
mips_ldst_top.sv
tb_mips_ldst.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_mips_ldst
FILELIST = mips_ldst.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG) || (echo "Simulation failed" && exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_mips_ldst.sv
`timescale 1ns/1ps

module tb_mips_ldst import mips_ldst_pkg::*; ();

    localparam opcode_t OPS [11] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
                                     OP_SB, OP_SH, OP_SW, OP_LUI};

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    word_t     mem_readdata = '0;
    logic      waitrequest = 1'b0;
    word_t     mem_address, mem_writedata, reg_writedata;
    byteen_t   mem_byteenable;
    logic      mem_readenable, mem_writeenable, reg_writeenable;
    reg_addr_t reg_writeaddr;

    word_t       bus_mem [word_t];          // Memory seen by the DUT
    word_t       ref_mem [word_t];          // Memory of the reference model
    word_t       ref_regs [NUM_REGS];
    word_t       prog [$];
    logic [36:0] exp_commit_q [$];          // {reg, data}
    logic [67:0] exp_write_q [$];           // {address, byteenable, data}
    logic [35:0] exp_read_q [$];            // {address, byteenable}
    logic [31:0] rng = 32'ha80b9469;
    logic        rd_pending = 1'b0, held = 1'b0, fetch_next = 1'b1, test_done = 1'b0;
    logic [69:0] held_bus;
    word_t       rd_addr, exp_pc;
    int          errors = 0, checks = 0, tests = 0;
    int          fetch_count, n_instr, commits, writes;
    int          cyc_count = 0;
    int          cyc_limit = 0;
    string       test_name = "";

    mips_ldst_top mips_ldst_top_i (.*);

    always #50 clk = ~clk;

    function automatic word_t xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Code region reads as zero (no-op), data region as an address hash
    function automatic word_t fill_word(word_t a);
        return (a < 32'h0001_0000) ? '0 : (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t ref_read(word_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    function automatic word_t bus_read(word_t a);
        return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
    endfunction

    function automatic word_t enc(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic is_mem_op(opcode_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
                          OP_SB, OP_SH, OP_SW};
    endfunction

    // Executes one instruction on the model and queues what the DUT must do
    function automatic void ref_step(word_t w);
        opcode_t op;
        int      rs, rt, b;
        word_t   a, al, m, rtv, res, wd;
        byteen_t be;
        logic    ld, st;
        op = w[31:26];
        rs = int'(w[25:21]);
        rt = int'(w[20:16]);
        a = ref_regs[rs] + {{16{w[15]}}, w[15:0]};
        al = {a[31:2], 2'b00};
        b = int'(a[1:0]);
        m = ref_read(al);
        rtv = ref_regs[rt];
        ld = 1'b1;
        st = 1'b0;
        res = '0;
        wd = '0;
        be = 4'hf;
        if (op inside {OP_LB, OP_LBU, OP_SB}) begin
            be = 4'b0001 << b;
        end else if (op inside {OP_LH, OP_LHU, OP_SH}) begin
            be = a[1] ? 4'b1100 : 4'b0011;
        end else if (op == OP_LWL) begin
            be = 4'hf >> (3 - b);                     // Lanes 0 up to b
        end else if (op == OP_LWR) begin
            be = 4'hf << b;                           // Lanes b up to 3
        end
        case (op)
            OP_LUI: res = {w[15:0], 16'h0000};
            OP_LB:  res = {{24{m[8*b+7]}}, m[8*b +: 8]};
            OP_LBU: res = {24'h0, m[8*b +: 8]};
            OP_LH:  res = {{16{m[16*int'(a[1])+15]}}, m[16*int'(a[1]) +: 16]};
            OP_LHU: res = {16'h0, m[16*int'(a[1]) +: 16]};
            OP_LW:  res = m;
            OP_LWL: res = (m << (8*(3-b))) | (rtv & ~(32'hffff_ffff << (8*(3-b))));
            OP_LWR: res = (m >> (8*b)) | (rtv & ~(32'hffff_ffff >> (8*b)));
            default: begin
                ld = 1'b0;
                st = op inside {OP_SB, OP_SH, OP_SW};
                if (op == OP_SB) begin
                    wd = {24'h0, rtv[7:0]} << (8*b);
                end else if (op == OP_SH) begin
                    wd = {16'h0, rtv[15:0]} << (16*int'(a[1]));
                end else begin
                    wd = rtv;
                end
            end
        endcase
        if (ld) begin
            if (op != OP_LUI) exp_read_q.push_back({al, be});
            exp_commit_q.push_back({5'(rt), res});
            if (rt != 0) ref_regs[rt] = res;          // $zero stays zero
        end
        if (st) begin
            exp_write_q.push_back({al, be, wd});
            for (int i = 0; i < 4; i++) begin
                if (be[i]) m[8*i +: 8] = wd[8*i +: 8];
            end
            ref_mem[al] = m;
        end
    endfunction

    task automatic value_mismatch(string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic protocol_error(string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    // Memory model driving all inputs on the falling edge
    always @(negedge clk) begin
        logic        wr;
        word_t       fw;
        logic [67:0] ew;
        logic [35:0] er;
        if (rd_pending) mem_readdata = bus_read(rd_addr);
        wr = (xorshift() % 3) == 0;
        waitrequest = wr;
        #1;
        if (!rst_n) begin
            rd_pending = 1'b0;
            held = 1'b0;
        end else begin
            if (held) begin
                checks++;
                if ({mem_address, mem_byteenable, mem_writedata, mem_readenable,
                     mem_writeenable} != held_bus)
                    value_mismatch("bus outputs changed while waitrequest was high");
            end
            held = wr && (mem_readenable || mem_writeenable);
            held_bus = {mem_address, mem_byteenable, mem_writedata, mem_readenable,
                        mem_writeenable};
            rd_pending = mem_readenable && !wr;
            rd_addr = mem_address;
            if (mem_readenable && !wr) begin
                if (fetch_next) begin
                    checks++;
                    if (mem_address != exp_pc || mem_byteenable != 4'hf)
                        value_mismatch($sformatf("fetch at %h be %b, expected %h be 1111",
                            mem_address, mem_byteenable, exp_pc));
                    fw = bus_read(mem_address);
                    fetch_next = !is_mem_op(fw[31:26]);
                    exp_pc += PC_STEP;
                    fetch_count++;
                    if (fetch_count == n_instr + 1) test_done = 1'b1;
                end else begin
                    fetch_next = 1'b1;
                    if (exp_read_q.size() == 0) begin
                        protocol_error("data read with no load left in the program");
                    end else begin
                        er = exp_read_q.pop_front();
                        checks++;
                        if (mem_address != er[35:4] || mem_byteenable != er[3:0])
                            value_mismatch($sformatf("read %h be %b, expected %h be %b",
                                mem_address, mem_byteenable, er[35:4], er[3:0]));
                    end
                end
            end
            if (mem_writeenable && !wr) begin
                if (fetch_next) protocol_error("bus write where an instruction fetch was due");
                fetch_next = 1'b1;
                writes++;
                if (exp_write_q.size() == 0) begin
                    protocol_error("bus write with no store left in the program");
                end else begin
                    ew = exp_write_q.pop_front();
                    checks++;
                    if (mem_address != ew[67:36] || mem_byteenable != ew[35:32] ||
                        (mem_writedata & {{8{ew[35]}}, {8{ew[34]}}, {8{ew[33]}},
                                          {8{ew[32]}}}) != ew[31:0])
                        value_mismatch($sformatf("write %h be %b data %h, expected %h be %b data %h",
                            mem_address, mem_byteenable, mem_writedata, ew[67:36], ew[35:32],
                            ew[31:0]));
                end
                fw = bus_read(mem_address);
                for (int i = 0; i < 4; i++) begin
                    if (mem_byteenable[i]) fw[8*i +: 8] = mem_writedata[8*i +: 8];
                end
                bus_mem[mem_address] = fw;
            end
        end
    end

    // Register commit compare
    always @(negedge clk) begin
        logic [36:0] ec;
        #1;
        if (rst_n && reg_writeenable) begin
            commits++;
            if (exp_commit_q.size() == 0) begin
                protocol_error("register write with no load or LUI left in the program");
            end else begin
                ec = exp_commit_q.pop_front();
                checks++;
                if ({reg_writeaddr, reg_writedata} != ec)
                    value_mismatch($sformatf("commit r%0d=%h, expected r%0d=%h", reg_writeaddr,
                        reg_writedata, ec[36:32], ec[31:0]));
            end
        end
    end

    // Watchdog on the cycles of the running test
    always @(posedge clk) begin
        if (rst_n && !test_done) begin
            cyc_count++;
            if (cyc_count >= cyc_limit) begin
                $display("ERROR: test %s timed out after %0d cycles", test_name, cyc_count);
                $display("Finished with errors");
                $finish;
            end
        end
    end

    task automatic run_test(string name);
        int err0;
        err0 = errors;
        @(negedge clk);
        rst_n = 1'b0;
        bus_mem.delete();
        ref_mem.delete();
        exp_commit_q.delete();
        exp_write_q.delete();
        exp_read_q.delete();
        foreach (ref_regs[i]) ref_regs[i] = '0;
        foreach (prog[i]) begin
            bus_mem[word_t'(4*i)] = prog[i];
            ref_mem[word_t'(4*i)] = prog[i];
        end
        foreach (prog[i]) ref_step(prog[i]);
        fetch_next = 1'b1;
        exp_pc = RESET_VECTOR;
        fetch_count = 0;
        n_instr = prog.size();
        commits = 0;
        writes = 0;
        test_done = 1'b0;
        test_name = name;
        cyc_count = 0;
        cyc_limit = n_instr * 3 * 4 + 10;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (!test_done) @(posedge clk);
        if (exp_commit_q.size() != 0 || exp_write_q.size() != 0)
            protocol_error($sformatf("%0d commits and %0d writes never happened",
                exp_commit_q.size(), exp_write_q.size()));
        tests++;
        $display("Test %-7s %0d instructions, %0d commits, %0d writes, %0d errors", name,
            n_instr, commits, writes, errors - err0);
    endtask

    // Base registers r1 to r3 point at data, r4 to r7 get random words
    task automatic start_program();
        prog.delete();
        prog.push_back(enc(OP_LUI, 0, 1, 16'h1000));
        prog.push_back(enc(OP_LUI, 0, 2, 16'h1001));
        prog.push_back(enc(OP_LUI, 0, 3, 16'h1000));
        for (int r = 4; r < 8; r++) prog.push_back(enc(OP_LW, 1, r, 4 * r));
    endtask

    task automatic add_random(int n);
        opcode_t op;
        int      rt;
        for (int i = 0; i < n; i++) begin
            op = OPS[xorshift() % 11];
            rt = (op inside {OP_SB, OP_SH, OP_SW}) ? 1 + int'(xorshift() % 7)
                                                   : 4 + int'(xorshift() % 4);
            prog.push_back(enc(op, 1 + int'(xorshift() % 3), rt,
                (op == OP_LUI) ? int'(xorshift() % 65536) : int'(xorshift() % 64) - 32));
        end
    endtask

    initial begin
        start_program();
        for (int r = 4; r < 8; r++) prog.push_back(enc(OP_LUI, 0, r, int'(xorshift() % 65536)));
        prog.push_back(enc(OP_LUI, 0, 0, 16'hbeef));
        prog.push_back(enc(OP_SW, 1, 0, 0));          // $zero must store as zero
        run_test("lui");

        start_program();
        for (int b = 0; b < 4; b++) begin
            prog.push_back(enc(OP_SB, 1, 4, b));
            prog.push_back(enc(OP_SH, 2, 5, b));
            prog.push_back(enc(OP_SW, 3, 6, 8 + b));
        end
        run_test("store");

        start_program();
        for (int b = 0; b < 8; b++) begin
            prog.push_back(enc(OP_LB, 1, 4, 16 + b));
            prog.push_back(enc(OP_LBU, 2, 5, 16 + b));
            prog.push_back(enc(OP_LH, 1, 6, 24 + b));
            prog.push_back(enc(OP_LHU, 2, 7, 24 + b));
        end
        run_test("load");

        start_program();
        for (int b = 0; b < 4; b++) begin
            prog.push_back(enc(OP_LWL, 2, 4, b));
            prog.push_back(enc(OP_LWR, 2, 5, b));
        end
        for (int a = 33; a < 36; a++) begin
            prog.push_back(enc(OP_LWR, 1, 6, a));     // Unaligned word from a pair
            prog.push_back(enc(OP_LWL, 1, 6, a + 3));
        end
        run_test("merge");

        start_program();
        add_random(24);
        run_test("stall");

        start_program();
        add_random(200);
        run_test("random");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: mips_ldst_top.sv
`timescale 1ns/1ps

module mips_ldst_top import mips_ldst_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // Avalon-style memory bus
    output word_t     mem_address,
    output byteen_t   mem_byteenable,
    output word_t     mem_writedata,
    output logic      mem_readenable,
    output logic      mem_writeenable,
    input  word_t     mem_readdata,
    input  logic      waitrequest,
    // Commit trace
    output logic      reg_writeenable,
    output reg_addr_t reg_writeaddr,
    output word_t     reg_writedata
);

    cycle_state_t state;
    word_t        pc;
    logic         exec1_first;
    logic         lb, lbu, lh, lhu, lui, lw, lwl, lwr, sb, sh, sw;
    reg_addr_t    rs;
    reg_addr_t    rt;
    imm16_t       offset;
    word_t        rs_data;
    word_t        rt_data;

    assign reg_writeaddr = rt;    // Loads and LUI target rt

    cycle_sequencer cycle_sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .waitrequest     (waitrequest),
        .mem_readenable  (mem_readenable),
        .mem_writeenable (mem_writeenable),
        .state           (state),
        .pc              (pc),
        .exec1_first     (exec1_first)
    );

    instr_decoder instr_decoder_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .exec1_first  (exec1_first),
        .mem_readdata (mem_readdata),
        .lb (lb), .lbu (lbu), .lh (lh), .lhu (lhu), .lui (lui), .lw (lw),
        .lwl (lwl), .lwr (lwr), .sb (sb), .sh (sh), .sw (sw),
        .rs           (rs),
        .rt           (rt),
        .offset       (offset)
    );

    load_store load_store_i (
        .state           (state),
        .pc              (pc),
        .lb (lb), .lbu (lbu), .lh (lh), .lhu (lhu), .lui (lui), .lw (lw),
        .lwl (lwl), .lwr (lwr), .sb (sb), .sh (sh), .sw (sw),
        .offset          (offset),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .mem_readdata    (mem_readdata),
        .mem_address     (mem_address),
        .mem_byteenable  (mem_byteenable),
        .mem_writedata   (mem_writedata),
        .mem_readenable  (mem_readenable),
        .mem_writeenable (mem_writeenable),
        .reg_writeenable (reg_writeenable),
        .reg_writedata   (reg_writedata)
    );

    register_file register_file_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .rs              (rs),
        .rt              (rt),
        .reg_writeenable (reg_writeenable),
        .reg_writeaddr   (reg_writeaddr),
        .reg_writedata   (reg_writedata),
        .rs_data         (rs_data),
        .rt_data         (rt_data)
    );

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file import mips_ldst_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      reg_writeenable,
    input  reg_addr_t reg_writeaddr,
    input  word_t     reg_writedata,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_writeenable && (reg_writeaddr != '0)) begin
            regs[reg_writeaddr] <= reg_writedata;   // $zero is never written
        end
    end

    // Asynchronous read ports
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

endmodule

// File: load_store.sv
`timescale 1ns/1ps

module load_store import mips_ldst_pkg::*; (
    input  cycle_state_t state,
    input  word_t        pc,
    input  logic         lb,
    input  logic         lbu,
    input  logic         lh,
    input  logic         lhu,
    input  logic         lui,
    input  logic         lw,
    input  logic         lwl,
    input  logic         lwr,
    input  logic         sb,
    input  logic         sh,
    input  logic         sw,
    input  imm16_t       offset,
    input  word_t        rs_data,
    input  word_t        rt_data,
    input  word_t        mem_readdata,
    output word_t        mem_address,
    output byteen_t      mem_byteenable,
    output word_t        mem_writedata,
    output logic         mem_readenable,
    output logic         mem_writeenable,
    output logic         reg_writeenable,
    output word_t        reg_writedata
);

    word_t       offset_ext;
    word_t       eff_addr;
    logic [1:0]  lane;
    logic        is_load;
    logic        is_store;
    byteen_t     byte_be;
    byteen_t     half_be;
    byteen_t     lwl_be;
    byteen_t     lwr_be;
    word_t       sb_data;
    word_t       sh_data;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       lwl_data;
    word_t       lwr_data;

    assign offset_ext = {{16{offset[15]}}, offset};
    assign eff_addr   = rs_data + offset_ext;
    assign lane       = eff_addr[1:0];
    assign is_load    = lb || lbu || lh || lhu || lw || lwl || lwr;
    assign is_store   = sb || sh || sw;

    // Instruction fetch in FETCH, data access otherwise
    assign mem_address = (state == FETCH) ? pc : {eff_addr[31:2], 2'b00};

    // Little-endian lane masks and store lanes
    always_comb begin
        case (lane)
            2'd0: begin
                byte_be = 4'b0001;
                lwl_be  = 4'b0001;
                lwr_be  = 4'b1111;
                sb_data = {24'h000000, rt_data[7:0]};
            end
            2'd1: begin
                byte_be = 4'b0010;
                lwl_be  = 4'b0011;
                lwr_be  = 4'b1110;
                sb_data = {16'h0000, rt_data[7:0], 8'h00};
            end
            2'd2: begin
                byte_be = 4'b0100;
                lwl_be  = 4'b0111;
                lwr_be  = 4'b1100;
                sb_data = {8'h00, rt_data[7:0], 16'h0000};
            end
            default: begin
                byte_be = 4'b1000;
                lwl_be  = 4'b1111;
                lwr_be  = 4'b1000;
                sb_data = {rt_data[7:0], 24'h000000};
            end
        endcase
        half_be = eff_addr[1] ? 4'b1100 : 4'b0011;             // Bit 0 is ignored
        sh_data = eff_addr[1] ? {rt_data[15:0], 16'h0000} : {16'h0000, rt_data[15:0]};
    end

    always_comb begin
        mem_readenable  = 1'b0;
        mem_writeenable = 1'b0;
        mem_byteenable  = 4'b1111;
        mem_writedata   = '0;
        case (state)
            FETCH: begin
                mem_readenable = 1'b1;                         // Whole instruction word
            end
            EXEC1: begin
                mem_readenable  = is_load;
                mem_writeenable = is_store;
                if (lb || lbu || sb) begin
                    mem_byteenable = byte_be;
                end else if (lh || lhu || sh) begin
                    mem_byteenable = half_be;
                end else if (lwl) begin
                    mem_byteenable = lwl_be;
                end else if (lwr) begin
                    mem_byteenable = lwr_be;
                end
                if (sw) begin
                    mem_writedata = rt_data;
                end else if (sh) begin
                    mem_writedata = sh_data;
                end else if (sb) begin
                    mem_writedata = sb_data;
                end
            end
            default: ;                                         // EXEC2 leaves the bus idle
        endcase
    end

    // Load data arrives in EXEC2 and is picked apart here
    always_comb begin
        case (lane)
            2'd0: begin
                load_byte = mem_readdata[7:0];
                lwl_data  = {mem_readdata[7:0], rt_data[23:0]};
                lwr_data  = mem_readdata;
            end
            2'd1: begin
                load_byte = mem_readdata[15:8];
                lwl_data  = {mem_readdata[15:0], rt_data[15:0]};
                lwr_data  = {rt_data[31:24], mem_readdata[31:8]};
            end
            2'd2: begin
                load_byte = mem_readdata[23:16];
                lwl_data  = {mem_readdata[23:0], rt_data[7:0]};
                lwr_data  = {rt_data[31:16], mem_readdata[31:16]};
            end
            default: begin
                load_byte = mem_readdata[31:24];
                lwl_data  = mem_readdata;
                lwr_data  = {rt_data[31:8], mem_readdata[31:24]};
            end
        endcase
        load_half = eff_addr[1] ? mem_readdata[31:16] : mem_readdata[15:0];
    end

    always_comb begin
        reg_writedata = '0;
        if (lb) begin
            reg_writedata = {{24{load_byte[7]}}, load_byte};
        end else if (lbu) begin
            reg_writedata = {24'h000000, load_byte};
        end else if (lh) begin
            reg_writedata = {{16{load_half[15]}}, load_half};
        end else if (lhu) begin
            reg_writedata = {16'h0000, load_half};
        end else if (lw) begin
            reg_writedata = mem_readdata;
        end else if (lwl) begin
            reg_writedata = lwl_data;                          // Upper bytes from memory
        end else if (lwr) begin
            reg_writedata = lwr_data;                          // Lower bytes from memory
        end else if (lui) begin
            reg_writedata = {offset, 16'h0000};
        end
    end

    // One-cycle commit pulse
    assign reg_writeenable = (state == EXEC2) && (is_load || lui);

endmodule

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import mips_ldst_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  cycle_state_t state,
    input  logic         exec1_first,
    input  word_t        mem_readdata,
    output logic         lb,
    output logic         lbu,
    output logic         lh,
    output logic         lhu,
    output logic         lui,
    output logic         lw,
    output logic         lwl,
    output logic         lwr,
    output logic         sb,
    output logic         sh,
    output logic         sw,
    output reg_addr_t    rs,
    output reg_addr_t    rt,
    output imm16_t       offset
);

    word_t   ir;
    word_t   instr;
    opcode_t opcode;
    logic    active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;                          // Opcode 0 decodes as no-op
        end else if (exec1_first) begin
            ir <= mem_readdata;
        end
    end

    // Fetched word is only on the bus during the first EXEC1 cycle
    assign instr  = exec1_first ? mem_readdata : ir;
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign offset = instr[15:0];
    assign active = (state == EXEC1) || (state == EXEC2);

    always_comb begin
        lb  = 1'b0;
        lbu = 1'b0;
        lh  = 1'b0;
        lhu = 1'b0;
        lui = 1'b0;
        lw  = 1'b0;
        lwl = 1'b0;
        lwr = 1'b0;
        sb  = 1'b0;
        sh  = 1'b0;
        sw  = 1'b0;
        if (active) begin
            case (opcode)
                OP_LB:   lb  = 1'b1;
                OP_LBU:  lbu = 1'b1;
                OP_LH:   lh  = 1'b1;
                OP_LHU:  lhu = 1'b1;
                OP_LUI:  lui = 1'b1;
                OP_LW:   lw  = 1'b1;
                OP_LWL:  lwl = 1'b1;
                OP_LWR:  lwr = 1'b1;
                OP_SB:   sb  = 1'b1;
                OP_SH:   sh  = 1'b1;
                OP_SW:   sw  = 1'b1;
                default: ;                     // Anything else runs as a no-op
            endcase
        end
    end

endmodule

// File: cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer import mips_ldst_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         waitrequest,
    input  logic         mem_readenable,
    input  logic         mem_writeenable,
    output cycle_state_t state,
    output word_t        pc,
    output logic         exec1_first
);

    logic         stall;
    cycle_state_t next_state;

    // Only a cycle with a pending bus access can be held off
    assign stall = waitrequest && (mem_readenable || mem_writeenable);

    always_comb begin
        next_state = state;
        if (!stall) begin
            case (state)
                FETCH:   next_state = EXEC1;
                EXEC1:   next_state = EXEC2;
                EXEC2:   next_state = FETCH;
                default: next_state = FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= FETCH;
            pc          <= RESET_VECTOR;
            exec1_first <= 1'b0;
        end else begin
            state       <= next_state;
            exec1_first <= (state == FETCH) && !stall;    // Instruction word is live next cycle
            if (state == EXEC2 && next_state == FETCH) begin
                pc <= pc + PC_STEP;
            end
        end
    end

endmodule

// File: mips_ldst_pkg.sv
package mips_ldst_pkg;

    // Basic widths
    typedef logic [31:0] word_t;        // Data word or byte address
    typedef logic [3:0]  byteen_t;      // One bit per byte lane
    typedef logic [4:0]  reg_addr_t;    // Register index
    typedef logic [15:0] imm16_t;       // Immediate offset field
    typedef logic [5:0]  opcode_t;      // Primary opcode field

    // Two-bit state codes
    typedef enum logic [1:0] {
        FETCH = 2'b00,
        EXEC1 = 2'b01,
        EXEC2 = 2'b10
    } cycle_state_t;

    // MIPS primary opcodes
    localparam opcode_t OP_LUI = 6'h0f;
    localparam opcode_t OP_LB  = 6'h20;
    localparam opcode_t OP_LH  = 6'h21;
    localparam opcode_t OP_LWL = 6'h22;
    localparam opcode_t OP_LW  = 6'h23;
    localparam opcode_t OP_LBU = 6'h24;
    localparam opcode_t OP_LHU = 6'h25;
    localparam opcode_t OP_LWR = 6'h26;
    localparam opcode_t OP_SB  = 6'h28;
    localparam opcode_t OP_SH  = 6'h29;
    localparam opcode_t OP_SW  = 6'h2b;

    // Program counter
    localparam word_t RESET_VECTOR = 32'h0000_0000;    // First fetch address
    localparam word_t PC_STEP      = 32'd4;            // One word per instruction

    // Register file
    localparam int NUM_REGS = 32;

endpackage
